/* dcache_pkg.sv */
package dcache_pkg;

    // byte address as seen by the core and on AXI
    typedef logic [31:0] addr_t;

    // one bus word, wishbone data and one AXI beat
    typedef logic [63:0] word_t;

    // byte selects for one word
    typedef logic [7:0] sel_t;

    // one cache line, word 0 in the low bits
    typedef logic [255:0] line_t;

    // beat number inside a burst
    typedef logic [1:0] beat_t;

    // every burst is INCR, full width, four beats, all bytes enabled
    localparam int LINE_BEATS = 4;

    // byte offset bits within a 32 byte line
    localparam int LINE_OFFSET_BITS = 5;

endpackage

/* dcache_core.sv */
`timescale 1ns/1ps

module dcache_core
    import dcache_pkg::*;
#(
    parameter int SETS = 16
)(
    input  logic  clock,
    input  logic  reset,

    // wishbone classic slave on the cpu side
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  logic  wb_we_i,
    input  addr_t wb_adr_i,
    input  word_t wb_dat_i,
    input  sel_t  wb_sel_i,
    output word_t wb_dat_o,
    output logic  wb_ack_o,

    // victim write-back towards the bridge
    output logic  evict_valid_o,
    output addr_t evict_addr_o,
    output line_t evict_line_o,
    input  logic  evict_ready_i,
    input  logic  evict_done_i,

    // line refill from the bridge
    output logic  fill_valid_o,
    output addr_t fill_addr_o,
    input  logic  fill_ready_i,
    input  logic  fill_beat_valid_i,
    input  word_t fill_beat_data_i,
    input  logic  fill_beat_last_i
);

    localparam int INDEX_BITS = $clog2(SETS);
    localparam int TAG_BITS   = $bits(addr_t) - INDEX_BITS - LINE_OFFSET_BITS;
    localparam int WORD_BITS  = $bits(word_t);
    localparam int BUF_BITS   = $bits(line_t) - WORD_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    typedef enum logic [2:0] {
        IDLE,
        HIT,        // ack cycle
        EVICT_REQ,
        EVICT_WAIT,
        FILL_REQ,
        FILL_WAIT,
        RESPOND     // merge store or latch load data
    } state_t;

    state_t state_q, state_d;

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    tag_t            tag_q  [SETS];
    line_t           data_q [SETS];

    logic [BUF_BITS-1:0] fill_buf_q;   // beats received before the last one
    word_t               rdata_q;

    index_t req_index;
    tag_t   req_tag;
    beat_t  req_word;
    line_t  cur_line;
    word_t  cur_word;
    line_t  fill_line;
    logic   req;
    logic   hit;
    logic   do_access;
    logic   fill_install;

    // byte-wise store merge
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < $bits(sel_t); b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // address split from wb_adr_i, held by the master until ack
    assign req_index = wb_adr_i[LINE_OFFSET_BITS +: INDEX_BITS];
    assign req_tag   = wb_adr_i[$bits(addr_t)-1 -: TAG_BITS];
    assign req_word  = wb_adr_i[LINE_OFFSET_BITS-1 -: $bits(beat_t)];

    assign cur_line = data_q[req_index];
    assign cur_word = cur_line[req_word*WORD_BITS +: WORD_BITS];

    assign req = wb_cyc_i && wb_stb_i;
    assign hit = valid_q[req_index] && (tag_q[req_index] == req_tag);

    // hit in IDLE or the retried access after a refill
    assign do_access = (state_q == IDLE && req && hit) || (state_q == RESPOND);

    // newest beat enters at the top so word 0 ends up in the low bits
    assign fill_line    = {fill_beat_data_i, fill_buf_q};
    assign fill_install = (state_q == FILL_WAIT) && fill_beat_valid_i && fill_beat_last_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req) begin
                    if (hit) begin
                        state_d = HIT;
                    end else if (valid_q[req_index] && dirty_q[req_index]) begin
                        state_d = EVICT_REQ;   // dirty victim goes out first
                    end else begin
                        state_d = FILL_REQ;
                    end
                end
            end
            HIT: begin
                state_d = IDLE;
            end
            EVICT_REQ: begin
                if (evict_ready_i) begin
                    state_d = EVICT_WAIT;
                end
            end
            EVICT_WAIT: begin
                if (evict_done_i) begin
                    state_d = FILL_REQ;
                end
            end
            FILL_REQ: begin
                if (fill_ready_i) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                if (fill_install) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = HIT;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // line status flags
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_install) begin
                valid_q[req_index] <= 1'b1;
                dirty_q[req_index] <= 1'b0;   // installed clean
            end
            if (do_access && wb_we_i) begin
                dirty_q[req_index] <= 1'b1;
            end
        end
    end

    // tags, line data and load data
    always_ff @(posedge clock) begin
        if (state_q == FILL_WAIT && fill_beat_valid_i) begin
            fill_buf_q <= fill_line[$bits(line_t)-1 -: BUF_BITS];
        end
        if (fill_install) begin
            tag_q[req_index]  <= req_tag;
            data_q[req_index] <= fill_line;
        end
        if (do_access) begin
            if (wb_we_i) begin
                data_q[req_index][req_word*WORD_BITS +: WORD_BITS] <=
                    merge_bytes(cur_word, wb_dat_i, wb_sel_i);
            end else begin
                rdata_q <= cur_word;
            end
        end
    end

    assign wb_ack_o = (state_q == HIT);
    assign wb_dat_o = rdata_q;

    // victim address rebuilt from the stored tag
    assign evict_valid_o = (state_q == EVICT_REQ);
    assign evict_addr_o  = {tag_q[req_index], req_index, {LINE_OFFSET_BITS{1'b0}}};
    assign evict_line_o  = cur_line;

    assign fill_valid_o = (state_q == FILL_REQ);
    assign fill_addr_o  = {wb_adr_i[$bits(addr_t)-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

endmodule

/* dcache_axi_bridge.sv */
`timescale 1ns/1ps

module dcache_axi_bridge
    import dcache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    // write-back requests from the core
    input  logic  evict_valid_i,
    input  addr_t evict_addr_i,
    input  line_t evict_line_i,
    output logic  evict_ready_o,
    output logic  evict_done_o,

    // refill requests from the core
    input  logic  fill_valid_i,
    input  addr_t fill_addr_i,
    output logic  fill_ready_o,
    output logic  fill_beat_valid_o,
    output word_t fill_beat_data_o,
    output logic  fill_beat_last_o,

    // AXI write channels
    output logic  axi_aw_valid_o,
    input  logic  axi_aw_ready_i,
    output addr_t axi_aw_addr_o,
    output logic  axi_w_valid_o,
    input  logic  axi_w_ready_i,
    output word_t axi_w_data_o,
    output logic  axi_w_last_o,
    input  logic  axi_b_valid_i,
    output logic  axi_b_ready_o,

    // AXI read channels
    output logic  axi_ar_valid_o,
    input  logic  axi_ar_ready_i,
    output addr_t axi_ar_addr_o,
    input  logic  axi_r_valid_i,
    output logic  axi_r_ready_o,
    input  word_t axi_r_data_i,
    input  logic  axi_r_last_i
);

    localparam int WORD_BITS = $bits(word_t);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } w_state_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } r_state_t;

    w_state_t w_state_q, w_state_d;
    r_state_t r_state_q, r_state_d;

    addr_t w_addr_q;
    line_t w_line_q;     // victim line held for the whole burst
    beat_t w_beat_q;
    logic  w_last;
    addr_t r_addr_q;

    assign w_last = (w_beat_q == beat_t'(LINE_BEATS - 1));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q <= W_IDLE;
            w_beat_q  <= '0;
        end else begin
            w_state_q <= w_state_d;
            if (evict_valid_i && evict_ready_o) begin
                w_beat_q <= '0;
            end else if (w_state_q == W_DATA && axi_w_ready_i) begin
                w_beat_q <= w_beat_q + beat_t'(1);   // one step per accepted beat
            end
        end
    end

    always_comb begin
        w_state_d = w_state_q;
        case (w_state_q)
            W_IDLE: begin
                if (evict_valid_i) begin
                    w_state_d = W_ADDR;
                end
            end
            W_ADDR: begin
                if (axi_aw_ready_i) begin
                    w_state_d = W_DATA;
                end
            end
            W_DATA: begin
                if (axi_w_ready_i && w_last) begin
                    w_state_d = W_RESP;
                end
            end
            W_RESP: begin
                if (axi_b_valid_i) begin
                    w_state_d = W_IDLE;
                end
            end
            default: begin
                w_state_d = W_IDLE;
            end
        endcase
    end

    // capture on the evict handshake
    always_ff @(posedge clock) begin
        if (evict_valid_i && evict_ready_o) begin
            w_addr_q <= evict_addr_i;
            w_line_q <= evict_line_i;
        end
    end

    assign evict_ready_o = (w_state_q == W_IDLE);
    assign evict_done_o  = (w_state_q == W_RESP) && axi_b_valid_i;   // B handshake

    assign axi_aw_valid_o = (w_state_q == W_ADDR);
    assign axi_aw_addr_o  = w_addr_q;
    assign axi_w_valid_o  = (w_state_q == W_DATA);
    assign axi_w_data_o   = w_line_q[w_beat_q*WORD_BITS +: WORD_BITS];
    assign axi_w_last_o   = w_last;
    assign axi_b_ready_o  = (w_state_q == W_RESP);   // held while waiting

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            r_state_q <= R_IDLE;
        end else begin
            r_state_q <= r_state_d;
        end
    end

    always_comb begin
        r_state_d = r_state_q;
        case (r_state_q)
            R_IDLE: begin
                if (fill_valid_i) begin
                    r_state_d = R_ADDR;
                end
            end
            R_ADDR: begin
                if (axi_ar_ready_i) begin
                    r_state_d = R_DATA;
                end
            end
            R_DATA: begin
                if (axi_r_valid_i && axi_r_last_i) begin
                    r_state_d = R_IDLE;
                end
            end
            default: begin
                r_state_d = R_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (fill_valid_i && fill_ready_o) begin
            r_addr_q <= fill_addr_i;
        end
    end

    assign fill_ready_o   = (r_state_q == R_IDLE);
    assign axi_ar_valid_o = (r_state_q == R_ADDR);
    assign axi_ar_addr_o  = r_addr_q;
    assign axi_r_ready_o  = (r_state_q == R_DATA);

    // R beats go straight through to the core
    assign fill_beat_valid_o = (r_state_q == R_DATA) && axi_r_valid_i;
    assign fill_beat_data_o  = axi_r_data_i;
    assign fill_beat_last_o  = fill_beat_valid_o && axi_r_last_i;

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int SETS = 16   // power of two
)(
    input  logic  clock,
    input  logic  reset,

    // wishbone classic slave
    input  logic  wb_cyc_i,
    input  logic  wb_stb_i,
    input  logic  wb_we_i,
    input  addr_t wb_adr_i,
    input  word_t wb_dat_i,
    input  sel_t  wb_sel_i,
    output word_t wb_dat_o,
    output logic  wb_ack_o,

    // AXI write channels
    output logic  axi_aw_valid_o,
    input  logic  axi_aw_ready_i,
    output addr_t axi_aw_addr_o,
    output logic  axi_w_valid_o,
    input  logic  axi_w_ready_i,
    output word_t axi_w_data_o,
    output logic  axi_w_last_o,
    input  logic  axi_b_valid_i,
    output logic  axi_b_ready_o,

    // AXI read channels
    output logic  axi_ar_valid_o,
    input  logic  axi_ar_ready_i,
    output addr_t axi_ar_addr_o,
    input  logic  axi_r_valid_i,
    output logic  axi_r_ready_o,
    input  word_t axi_r_data_i,
    input  logic  axi_r_last_i
);

    // core to bridge
    logic  evict_valid;
    logic  evict_ready;
    addr_t evict_addr;
    line_t evict_line;
    logic  evict_done;
    logic  fill_valid;
    logic  fill_ready;
    addr_t fill_addr;
    logic  fill_beat_valid;
    word_t fill_beat_data;
    logic  fill_beat_last;

    dcache_core #(
        .SETS (SETS)
    ) u_core (
        .clock             (clock),
        .reset             (reset),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_sel_i          (wb_sel_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .evict_valid_o     (evict_valid),
        .evict_addr_o      (evict_addr),
        .evict_line_o      (evict_line),
        .evict_ready_i     (evict_ready),
        .evict_done_i      (evict_done),
        .fill_valid_o      (fill_valid),
        .fill_addr_o       (fill_addr),
        .fill_ready_i      (fill_ready),
        .fill_beat_valid_i (fill_beat_valid),
        .fill_beat_data_i  (fill_beat_data),
        .fill_beat_last_i  (fill_beat_last)
    );

    dcache_axi_bridge u_bridge (
        .clock             (clock),
        .reset             (reset),
        .evict_valid_i     (evict_valid),
        .evict_addr_i      (evict_addr),
        .evict_line_i      (evict_line),
        .evict_ready_o     (evict_ready),
        .evict_done_o      (evict_done),
        .fill_valid_i      (fill_valid),
        .fill_addr_i       (fill_addr),
        .fill_ready_o      (fill_ready),
        .fill_beat_valid_o (fill_beat_valid),
        .fill_beat_data_o  (fill_beat_data),
        .fill_beat_last_o  (fill_beat_last),
        .axi_aw_valid_o    (axi_aw_valid_o),
        .axi_aw_ready_i    (axi_aw_ready_i),
        .axi_aw_addr_o     (axi_aw_addr_o),
        .axi_w_valid_o     (axi_w_valid_o),
        .axi_w_ready_i     (axi_w_ready_i),
        .axi_w_data_o      (axi_w_data_o),
        .axi_w_last_o      (axi_w_last_o),
        .axi_b_valid_i     (axi_b_valid_i),
        .axi_b_ready_o     (axi_b_ready_o),
        .axi_ar_valid_o    (axi_ar_valid_o),
        .axi_ar_ready_i    (axi_ar_ready_i),
        .axi_ar_addr_o     (axi_ar_addr_o),
        .axi_r_valid_i     (axi_r_valid_i),
        .axi_r_ready_o     (axi_r_ready_o),
        .axi_r_data_i      (axi_r_data_i),
        .axi_r_last_i      (axi_r_last_i)
    );

endmodule

/* tb_axi_mem.sv */
`timescale 1ns/1ps

module tb_axi_mem
    import dcache_pkg::*;
(
    input  logic  clock,
    input  logic  reset,

    // write channels
    input  logic  aw_valid_i,
    output logic  aw_ready_o,
    input  addr_t aw_addr_i,
    input  logic  w_valid_i,
    output logic  w_ready_o,
    input  word_t w_data_i,
    input  logic  w_last_i,
    output logic  b_valid_o,
    input  logic  b_ready_i,

    // read channels
    input  logic  ar_valid_i,
    output logic  ar_ready_o,
    input  addr_t ar_addr_i,
    output logic  r_valid_o,
    input  logic  r_ready_i,
    output word_t r_data_o,
    output logic  r_last_o,

    // traffic seen by the memory
    output int    aw_count_o,
    output addr_t aw_addr_last_o,
    output int    ar_count_o,
    output int    error_count_o
);

    localparam logic [31:0] LFSR_SEED = 32'ha430;

    word_t       mem [addr_t];   // only words written by a burst
    logic [31:0] lfsr;
    addr_t       wr_addr;
    int          wr_beats;
    logic        wr_open;        // AW taken, W beats expected
    logic        b_pending;
    logic        b_taken;
    addr_t       rd_addr;
    int          rd_beats;
    logic        rd_open;
    logic        r_taken;
    logic        offer;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    function automatic addr_t beat_addr(addr_t base, int beat);
        return {base[31:3], 3'b000} + addr_t'(beat * 8);
    endfunction

    function automatic word_t mem_read(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a, ~a};   // untouched word, address and its inverse
    endfunction

    task automatic protocol_error(string msg);
        $display("%0t: memory model: %s", $time, msg);
        error_count_o = error_count_o + 1;
    endtask

    task automatic clear_state();
        aw_ready_o     = 1'b0;
        w_ready_o      = 1'b0;
        b_valid_o      = 1'b0;
        ar_ready_o     = 1'b0;
        r_valid_o      = 1'b0;
        r_data_o       = '0;
        r_last_o       = 1'b0;
        aw_count_o     = 0;
        aw_addr_last_o = '0;
        ar_count_o     = 0;
        error_count_o  = 0;
        wr_addr        = '0;
        wr_beats       = 0;
        wr_open        = 1'b0;
        b_pending      = 1'b0;
        b_taken        = 1'b0;
        rd_addr        = '0;
        rd_beats       = 0;
        rd_open        = 1'b0;
        r_taken        = 1'b0;
        lfsr           = LFSR_SEED;
    endtask

    // runs on the falling edge, decides what transfers on the next rising edge
    task automatic step_channels();
        if (b_taken) b_valid_o = 1'b0;
        if (r_taken) r_valid_o = 1'b0;

        draw_bit(aw_ready_o);
        draw_bit(w_ready_o);
        draw_bit(ar_ready_o);

        if (b_pending && !b_valid_o) begin
            draw_bit(offer);
            if (offer) begin
                b_valid_o = 1'b1;
                b_pending = 1'b0;
            end
        end
        if (rd_open && !r_valid_o) begin   // a raised R beat is held until taken
            draw_bit(offer);
            if (offer) begin
                r_valid_o = 1'b1;
                r_data_o  = mem_read(beat_addr(rd_addr, rd_beats));
                r_last_o  = (rd_beats == LINE_BEATS - 1);
            end
        end

        b_taken = b_valid_o && b_ready_i;
        r_taken = r_valid_o && r_ready_i;
        if (r_taken) begin
            rd_beats = rd_beats + 1;
            if (r_last_o) rd_open = 1'b0;
        end

        if (w_valid_i && w_ready_o) begin
            if (!wr_open) begin
                protocol_error("W beat arrived with no write burst open");
            end else begin
                mem[beat_addr(wr_addr, wr_beats)] = w_data_i;
                wr_beats = wr_beats + 1;
                if (w_last_i && wr_beats != LINE_BEATS) begin
                    protocol_error($sformatf("write burst to %h has wlast on beat %0d",
                                             wr_addr, wr_beats));
                end
                if (!w_last_i && wr_beats >= LINE_BEATS) begin
                    protocol_error($sformatf("write burst to %h has beat %0d without wlast",
                                             wr_addr, wr_beats));
                end
                if (w_last_i) begin
                    wr_open   = 1'b0;
                    b_pending = 1'b1;
                end
            end
        end

        if (aw_valid_i && aw_ready_o) begin
            if (wr_open || b_pending || b_valid_o) begin
                protocol_error("AW taken while the previous write burst was still open");
            end
            if (aw_addr_i[LINE_OFFSET_BITS-1:0] != '0) begin
                protocol_error($sformatf("AW address %h is not line aligned", aw_addr_i));
            end
            wr_addr        = aw_addr_i;
            wr_beats       = 0;
            wr_open        = 1'b1;
            aw_count_o     = aw_count_o + 1;
            aw_addr_last_o = aw_addr_i;
        end

        if (ar_valid_i && ar_ready_o) begin
            if (rd_open) begin
                protocol_error("AR taken while the previous read burst was still open");
            end
            rd_addr    = ar_addr_i;
            rd_beats   = 0;
            rd_open    = 1'b1;
            ar_count_o = ar_count_o + 1;
        end
    endtask

    initial begin
        clear_state();
        forever begin
            @(negedge clock);
            if (!reset) begin
                clear_state();
            end else begin
                step_channels();
            end
        end
    end

endmodule

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int SETS         = 16;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int ROW_CYCLES   = 300;   // ack budget per row

    logic  clock;
    logic  reset;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    word_t wb_dat_w;
    sel_t  wb_sel;
    word_t wb_dat_r;
    logic  wb_ack;

    logic  aw_valid;
    logic  aw_ready;
    addr_t aw_addr;
    logic  w_valid;
    logic  w_ready;
    word_t w_data;
    logic  w_last;
    logic  b_valid;
    logic  b_ready;
    logic  ar_valid;
    logic  ar_ready;
    addr_t ar_addr;
    logic  r_valid;
    logic  r_ready;
    word_t r_data;
    logic  r_last;

    int    aw_count;
    addr_t aw_addr_last;
    int    ar_count;
    int    mem_errors;

    // stimulus table, one entry per wishbone cycle
    logic  row_write   [$];
    addr_t row_addr    [$];
    word_t row_data    [$];
    sel_t  row_sel     [$];
    int    row_ar      [$];   // AR handshakes expected during the row
    int    row_aw      [$];   // write bursts expected during the row
    addr_t row_aw_addr [$];   // victim line when one burst is expected

    word_t shadow [addr_t];
    int    num_rows;
    int    passes;
    int    fails;
    int    idle_errors;

    dcache_top #(
        .SETS (SETS)
    ) dut (
        .clock          (clock),
        .reset          (reset),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_sel_i       (wb_sel),
        .wb_dat_o       (wb_dat_r),
        .wb_ack_o       (wb_ack),
        .axi_aw_valid_o (aw_valid),
        .axi_aw_ready_i (aw_ready),
        .axi_aw_addr_o  (aw_addr),
        .axi_w_valid_o  (w_valid),
        .axi_w_ready_i  (w_ready),
        .axi_w_data_o   (w_data),
        .axi_w_last_o   (w_last),
        .axi_b_valid_i  (b_valid),
        .axi_b_ready_o  (b_ready),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_addr_o  (ar_addr),
        .axi_r_valid_i  (r_valid),
        .axi_r_ready_o  (r_ready),
        .axi_r_data_i   (r_data),
        .axi_r_last_i   (r_last)
    );

    tb_axi_mem u_mem (
        .clock          (clock),
        .reset          (reset),
        .aw_valid_i     (aw_valid),
        .aw_ready_o     (aw_ready),
        .aw_addr_i      (aw_addr),
        .w_valid_i      (w_valid),
        .w_ready_o      (w_ready),
        .w_data_i       (w_data),
        .w_last_i       (w_last),
        .b_valid_o      (b_valid),
        .b_ready_i      (b_ready),
        .ar_valid_i     (ar_valid),
        .ar_ready_o     (ar_ready),
        .ar_addr_i      (ar_addr),
        .r_valid_o      (r_valid),
        .r_ready_i      (r_ready),
        .r_data_o       (r_data),
        .r_last_o       (r_last),
        .aw_count_o     (aw_count),
        .aw_addr_last_o (aw_addr_last),
        .ar_count_o     (ar_count),
        .error_count_o  (mem_errors)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    function automatic addr_t word_key(addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    // memory starts as address and inverted address per word
    function automatic word_t shadow_read(addr_t a);
        if (shadow.exists(word_key(a))) begin
            return shadow[word_key(a)];
        end
        return {word_key(a), ~word_key(a)};
    endfunction

    function automatic word_t byte_mask(sel_t sel);
        word_t m;
        for (int i = 0; i < 8; i++) begin
            m[i*8 +: 8] = {8{sel[i]}};
        end
        return m;
    endfunction

    task automatic add_row(logic write, addr_t addr, word_t data, sel_t sel,
                           int ars, int aws, addr_t victim);
        row_write.push_back(write);
        row_addr.push_back(addr);
        row_data.push_back(data);
        row_sel.push_back(sel);
        row_ar.push_back(ars);
        row_aw.push_back(aws);
        row_aw_addr.push_back(victim);
    endtask

    // 16 sets of 32 bytes, addresses 0x200 apart share a set
    task automatic build_table();
        add_row(0, 32'h0000_1000, '0, 8'hff, 1, 0, '0);   // cold miss, set 0
        add_row(0, 32'h0000_1008, '0, 8'hff, 0, 0, '0);   // same line, no new AR
        add_row(0, 32'h0000_1018, '0, 8'hff, 0, 0, '0);
        add_row(1, 32'h0000_1008, 64'h1122_3344_5566_7788, 8'h0f, 0, 0, '0);
        add_row(1, 32'h0000_1008, 64'ha5a5_5a5a_c3c3_3c3c, 8'h3c, 0, 0, '0);
        add_row(0, 32'h0000_1008, '0, 8'hff, 0, 0, '0);   // merged bytes
        add_row(1, 32'h0000_1010, 64'hdead_beef_0bad_f00d, 8'hff, 0, 0, '0);
        add_row(0, 32'h0000_1200, '0, 8'hff, 1, 1, 32'h0000_1000);   // dirty victim
        add_row(0, 32'h0000_1008, '0, 8'hff, 1, 0, '0);   // back from memory
        add_row(0, 32'h0000_1010, '0, 8'hff, 0, 0, '0);
        add_row(1, 32'h0000_2048, 64'h0123_4567_89ab_cdef, 8'h81, 1, 0, '0);   // store miss
        add_row(0, 32'h0000_2048, '0, 8'hff, 0, 0, '0);
        add_row(1, 32'h0000_2448, 64'hfedc_ba98_7654_3210, 8'hff, 1, 1, 32'h0000_2040);
        add_row(0, 32'h0000_2048, '0, 8'hff, 1, 1, 32'h0000_2440);
        add_row(0, 32'h0000_2448, '0, 8'hff, 1, 0, '0);
        add_row(1, 32'h0000_30f8, 64'h5555_aaaa_3333_cccc, 8'hff, 1, 0, '0);
        add_row(1, 32'h0000_32f0, 64'h0f0f_f0f0_1234_5678, 8'h0f, 1, 1, 32'h0000_30e0);
        add_row(0, 32'h0000_30f8, '0, 8'hff, 1, 1, 32'h0000_32e0);
        add_row(0, 32'h0000_32f0, '0, 8'hff, 1, 0, '0);
        add_row(0, 32'h0000_0000, '0, 8'hff, 1, 0, '0);
        add_row(0, 32'hffff_fff8, '0, 8'hff, 1, 0, '0);   // top of memory, set 15
        add_row(1, 32'hffff_ffe0, 64'h7766_5544_3322_1100, 8'h55, 0, 0, '0);
        add_row(0, 32'hffff_ffe0, '0, 8'hff, 0, 0, '0);
        add_row(0, 32'h0000_01e0, '0, 8'hff, 1, 1, 32'hffff_ffe0);
        add_row(0, 32'hffff_ffe0, '0, 8'hff, 1, 0, '0);
    endtask

    task automatic check_idle_after_reset();
        for (int c = 0; c < 4; c++) begin
            if (wb_ack || aw_valid || w_valid || ar_valid || b_ready || r_ready) begin
                $display("ERR %0t: outputs busy after reset, ack %b aw %b w %b ar %b b %b r %b",
                         $time, wb_ack, aw_valid, w_valid, ar_valid, b_ready, r_ready);
                idle_errors = idle_errors + 1;
            end
            @(negedge clock);
        end
        if (idle_errors == 0) begin
            $display("reset idle check: ok");
        end else begin
            $display("reset idle check: FAILED");
        end
    endtask

    task automatic run_row(int r);
        int    ar_before;
        int    aw_before;
        int    cycles;
        int    errs;
        word_t expected;
        word_t got;
        word_t mask;
        ar_before = ar_count;
        aw_before = aw_count;
        cycles    = 0;
        errs      = 0;
        expected  = shadow_read(row_addr[r]);

        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = row_write[r];
        wb_adr   = row_addr[r];
        wb_dat_w = row_data[r];
        wb_sel   = row_sel[r];
        do begin
            @(negedge clock);
            cycles = cycles + 1;
        end while (!wb_ack && cycles < ROW_CYCLES);
        got    = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;

        if (!wb_ack) begin
            $display("row %0d: the cache gave no ack within %0d cycles", r, ROW_CYCLES);
            errs = errs + 1;
        end else if (row_write[r]) begin
            mask = byte_mask(row_sel[r]);
            shadow[word_key(row_addr[r])] = (expected & ~mask) | (row_data[r] & mask);
        end else if (got !== expected) begin
            $display("ERR %0t: row %0d read %h, expected %h", $time, r, got, expected);
            errs = errs + 1;
        end
        if (ar_count - ar_before != row_ar[r]) begin
            $display("ERR %0t: row %0d saw %0d AR handshakes, expected %0d",
                     $time, r, ar_count - ar_before, row_ar[r]);
            errs = errs + 1;
        end
        if (aw_count - aw_before != row_aw[r]) begin
            $display("ERR %0t: row %0d saw %0d write bursts, expected %0d",
                     $time, r, aw_count - aw_before, row_aw[r]);
            errs = errs + 1;
        end
        if (row_aw[r] == 1 && aw_addr_last != row_aw_addr[r]) begin
            $display("ERR %0t: row %0d wrote back line %h, expected %h",
                     $time, r, aw_addr_last, row_aw_addr[r]);
            errs = errs + 1;
        end

        @(negedge clock);   // bus idle for one cycle
        if (wb_ack) begin
            $display("ERR %0t: row %0d ack stayed high past one cycle", $time, r);
            errs = errs + 1;
        end

        if (errs == 0) begin
            $display("row %0d %s %h: ok", r, row_write[r] ? "write" : "read ", row_addr[r]);
            passes = passes + 1;
        end else begin
            $display("row %0d %s %h: FAILED", r, row_write[r] ? "write" : "read ", row_addr[r]);
            fails = fails + 1;
        end
    endtask

    initial begin
        reset       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_sel      = '0;
        passes      = 0;
        fails       = 0;
        idle_errors = 0;
        build_table();
        num_rows = row_addr.size();

        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b1;
        check_idle_after_reset();

        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end

        $display("summary: %0d rows, %0d passed, %0d failed, %0d reset errors, %0d protocol errors",
                 num_rows, passes, fails, idle_errors, mem_errors);
        if (fails == 0 && idle_errors == 0 && mem_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // run limit from the table length
    initial begin
        wait (num_rows > 0);
        #(CLK_PERIOD * (ROW_CYCLES * num_rows + RESET_CYCLES));
        $display("timeout: the table of %0d rows did not finish in time", num_rows);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* compile.f */
dcache_pkg.sv
dcache_core.sv
dcache_axi_bridge.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv

/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
